// ==== Makefile ====
# Verilator build of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= exe_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the binary exits non-zero on $fatal, so make reports the failure
run: $(BINARY)
	./$(BINARY)

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
hdl/exe_pkg.sv
hdl/exe_decode.sv
hdl/exe_alu.sv
hdl/exe_branch.sv
hdl/exe_stage.sv
verif/tb_clock.sv
verif/exe_tb.sv

// ==== hdl/exe_alu.sv ====
`timescale 1ns/1ns

module exe_alu (
  input  exe_pkg::exe_in_t             insn_in,
  input  exe_pkg::insn_class_e         insn_class,
  input  exe_pkg::alu_op_e             alu_op,
  output logic [exe_pkg::xlen-1:0]     result,
  output logic                         is_long,
  output logic [exe_pkg::xlen-1:0]     mem_addr
);

  logic [exe_pkg::xlen-1:0] opa;
  logic [exe_pkg::xlen-1:0] opb;
  logic [5:0]               shamt;
  logic                     is_word;
  logic [exe_pkg::xlen-1:0] res64;
  logic [31:0]              a32;
  logic [31:0]              b32;
  logic [31:0]              res32;

  assign opa = insn_in.src1;

  // register classes take src2, the rest the immediate
  assign opb = (insn_class == exe_pkg::cls_op || insn_class == exe_pkg::cls_op_32) ?
               insn_in.src2 : insn_in.imm;

  assign is_word = (insn_class == exe_pkg::cls_op_32) ||
                   (insn_class == exe_pkg::cls_op_imm_32);

  // word shifts only look at 5 bits
  assign shamt = is_word ? {1'b0, opb[4:0]} : opb[5:0];

  // full width ops
  always_comb begin
    case (alu_op)
      exe_pkg::alu_sub:  res64 = opa - opb;
      exe_pkg::alu_sll:  res64 = opa << shamt;
      exe_pkg::alu_slt:  res64 = {{(exe_pkg::xlen-1){1'b0}}, $signed(opa) < $signed(opb)};
      exe_pkg::alu_sltu: res64 = {{(exe_pkg::xlen-1){1'b0}}, opa < opb};
      exe_pkg::alu_xor:  res64 = opa ^ opb;
      exe_pkg::alu_srl:  res64 = opa >> shamt;
      exe_pkg::alu_sra:  res64 = $signed(opa) >>> shamt;
      exe_pkg::alu_or:   res64 = opa | opb;
      exe_pkg::alu_and:  res64 = opa & opb;
      default:           res64 = opa + opb;
    endcase
  end

  // word ops on the low half
  assign a32 = opa[31:0];
  assign b32 = opb[31:0];

  always_comb begin
    case (alu_op)
      exe_pkg::alu_sub: res32 = a32 - b32;
      exe_pkg::alu_sll: res32 = a32 << shamt[4:0];
      exe_pkg::alu_srl: res32 = a32 >> shamt[4:0];
      // sraw shifts in bit 31, not bit 63
      exe_pkg::alu_sra: res32 = $signed(a32) >>> shamt[4:0];
      default:          res32 = a32 + b32;
    endcase
  end

  // pick result by class
  always_comb begin
    is_long = 1'b1;
    case (insn_class)
      exe_pkg::cls_op_32, exe_pkg::cls_op_imm_32: begin
        // sign extend from bit 31
        result  = {{32{res32[31]}}, res32};
        is_long = 1'b0;
      end
      exe_pkg::cls_auipc: result = insn_in.pc + insn_in.imm;
      // link value
      exe_pkg::cls_jal, exe_pkg::cls_jalr: result = insn_in.pc + 64'd4;
      default: result = res64;
    endcase
  end

  // load/store effective address
  assign mem_addr = insn_in.src1 + insn_in.imm;

endmodule

// ==== hdl/exe_branch.sv ====
`timescale 1ns/1ns

module exe_branch #(
  parameter logic [exe_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         insn_valid,
  input  exe_pkg::exe_in_t             insn_in,
  input  exe_pkg::insn_class_e         insn_class,
  input  exe_pkg::br_cond_e            br_cond,
  output logic                         accept,
  output logic                         taken,
  output logic [exe_pkg::xlen-1:0]     target
);

  // pc of the next instruction on the correct path
  logic [exe_pkg::xlen-1:0] expect_pc;
  logic [exe_pkg::xlen-1:0] jalr_sum;
  logic                     cond_true;

  // branch compare
  always_comb begin
    case (br_cond)
      exe_pkg::bne:  cond_true = insn_in.src1 != insn_in.src2;
      exe_pkg::blt:  cond_true = $signed(insn_in.src1) < $signed(insn_in.src2);
      exe_pkg::bge:  cond_true = $signed(insn_in.src1) >= $signed(insn_in.src2);
      exe_pkg::bltu: cond_true = insn_in.src1 < insn_in.src2;
      exe_pkg::bgeu: cond_true = insn_in.src1 >= insn_in.src2;
      default:       cond_true = insn_in.src1 == insn_in.src2;
    endcase
  end

  // wrong path filter
  // anything off the expected pc is dropped
  assign accept = insn_valid && (insn_in.pc == expect_pc);

  assign jalr_sum = insn_in.src1 + insn_in.imm;

  always_comb begin
    taken  = 1'b0;
    target = insn_in.pc + insn_in.imm;
    case (insn_class)
      exe_pkg::cls_branch: taken = accept && cond_true;
      exe_pkg::cls_jal:    taken = accept;
      exe_pkg::cls_jalr: begin
        taken  = accept;
        // jalr clears bit 0
        target = {jalr_sum[exe_pkg::xlen-1:1], 1'b0};
      end
      default: taken = 1'b0;
    endcase
  end

  // advance on every accepted insn, illegal included
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      expect_pc <= reset_pc;
    end else if (accept) begin
      expect_pc <= taken ? target : insn_in.pc + 64'd4;
    end
  end

  // a valid insn needs a known pc for the filter compare
  pc_known_a: assert property (
    @(posedge clk) disable iff (!arst_n)
    insn_valid |-> !$isunknown(insn_in.pc)
  );

endmodule

// ==== hdl/exe_decode.sv ====
`timescale 1ns/1ns

module exe_decode (
  input  logic [31:0]          insn,
  output exe_pkg::insn_class_e insn_class,
  output exe_pkg::alu_op_e     alu_op,
  output exe_pkg::br_cond_e    br_cond,
  output exe_pkg::mem_op_e     mem_op
);

  // funct7 patterns, alt selects sub/sra
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

  exe_pkg::opcode_e opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [5:0]       funct6;

  assign opcode = exe_pkg::opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  // rv64 imm shifts use insn[25] as shamt bit 5
  assign funct6 = insn[31:26];

  always_comb begin
    // safe defaults, anything unlisted ends up illegal
    insn_class = exe_pkg::cls_illegal;
    alu_op     = exe_pkg::alu_add;
    br_cond    = exe_pkg::beq;
    mem_op     = exe_pkg::lb;
    case (opcode)
      exe_pkg::opc_op: begin
        insn_class = exe_pkg::cls_op;
        case ({funct7, funct3})
          {f7_base, 3'd0}: alu_op = exe_pkg::alu_add;
          {f7_alt,  3'd0}: alu_op = exe_pkg::alu_sub;
          {f7_base, 3'd1}: alu_op = exe_pkg::alu_sll;
          {f7_base, 3'd2}: alu_op = exe_pkg::alu_slt;
          {f7_base, 3'd3}: alu_op = exe_pkg::alu_sltu;
          {f7_base, 3'd4}: alu_op = exe_pkg::alu_xor;
          {f7_base, 3'd5}: alu_op = exe_pkg::alu_srl;
          {f7_alt,  3'd5}: alu_op = exe_pkg::alu_sra;
          {f7_base, 3'd6}: alu_op = exe_pkg::alu_or;
          {f7_base, 3'd7}: alu_op = exe_pkg::alu_and;
          default:         insn_class = exe_pkg::cls_illegal;
        endcase
      end
      exe_pkg::opc_op_imm: begin
        insn_class = exe_pkg::cls_op_imm;
        case (funct3)
          3'd0: alu_op = exe_pkg::alu_add;
          3'd2: alu_op = exe_pkg::alu_slt;
          3'd3: alu_op = exe_pkg::alu_sltu;
          3'd4: alu_op = exe_pkg::alu_xor;
          3'd6: alu_op = exe_pkg::alu_or;
          3'd7: alu_op = exe_pkg::alu_and;
          3'd1: begin
            alu_op = exe_pkg::alu_sll;
            if (funct6 != f7_base[6:1]) insn_class = exe_pkg::cls_illegal;
          end
          default: begin
            // funct3 5, srli or srai by funct6
            if (funct6 == f7_base[6:1]) alu_op = exe_pkg::alu_srl;
            else if (funct6 == f7_alt[6:1]) alu_op = exe_pkg::alu_sra;
            else insn_class = exe_pkg::cls_illegal;
          end
        endcase
      end
      exe_pkg::opc_op_32: begin
        insn_class = exe_pkg::cls_op_32;
        case ({funct7, funct3})
          {f7_base, 3'd0}: alu_op = exe_pkg::alu_add;
          {f7_alt,  3'd0}: alu_op = exe_pkg::alu_sub;
          {f7_base, 3'd1}: alu_op = exe_pkg::alu_sll;
          {f7_base, 3'd5}: alu_op = exe_pkg::alu_srl;
          {f7_alt,  3'd5}: alu_op = exe_pkg::alu_sra;
          default:         insn_class = exe_pkg::cls_illegal;
        endcase
      end
      exe_pkg::opc_op_imm_32: begin
        insn_class = exe_pkg::cls_op_imm_32;
        // addiw ignores funct7, it is immediate
        if (funct3 == 3'd0) alu_op = exe_pkg::alu_add;
        else if ({funct7, funct3} == {f7_base, 3'd1}) alu_op = exe_pkg::alu_sll;
        else if ({funct7, funct3} == {f7_base, 3'd5}) alu_op = exe_pkg::alu_srl;
        else if ({funct7, funct3} == {f7_alt, 3'd5}) alu_op = exe_pkg::alu_sra;
        else insn_class = exe_pkg::cls_illegal;
      end
      exe_pkg::opc_auipc: insn_class = exe_pkg::cls_auipc;
      exe_pkg::opc_branch: begin
        insn_class = exe_pkg::cls_branch;
        case (funct3)
          3'd0:    br_cond = exe_pkg::beq;
          3'd1:    br_cond = exe_pkg::bne;
          3'd4:    br_cond = exe_pkg::blt;
          3'd5:    br_cond = exe_pkg::bge;
          3'd6:    br_cond = exe_pkg::bltu;
          3'd7:    br_cond = exe_pkg::bgeu;
          default: insn_class = exe_pkg::cls_illegal;
        endcase
      end
      exe_pkg::opc_jal: insn_class = exe_pkg::cls_jal;
      exe_pkg::opc_jalr: begin
        if (funct3 == 3'd0) insn_class = exe_pkg::cls_jalr;
      end
      exe_pkg::opc_load: begin
        insn_class = exe_pkg::cls_load;
        case (funct3)
          3'd0:    mem_op = exe_pkg::lb;
          3'd1:    mem_op = exe_pkg::lh;
          3'd2:    mem_op = exe_pkg::lw;
          3'd3:    mem_op = exe_pkg::ld;
          3'd4:    mem_op = exe_pkg::lbu;
          3'd5:    mem_op = exe_pkg::lhu;
          3'd6:    mem_op = exe_pkg::lwu;
          default: insn_class = exe_pkg::cls_illegal;
        endcase
      end
      exe_pkg::opc_store: begin
        insn_class = exe_pkg::cls_store;
        case (funct3)
          3'd0:    mem_op = exe_pkg::sb;
          3'd1:    mem_op = exe_pkg::sh;
          3'd2:    mem_op = exe_pkg::sw;
          3'd3:    mem_op = exe_pkg::sd;
          default: insn_class = exe_pkg::cls_illegal;
        endcase
      end
      default: insn_class = exe_pkg::cls_illegal;
    endcase
  end

endmodule

// ==== hdl/exe_pkg.sv ====
package exe_pkg;

  // datapath width for operands, pc and results
  localparam int xlen = 64;

  typedef logic [4:0] reg_idx_t;

  // major opcodes handled by the execute stage
  typedef enum logic [6:0] {
    opc_load      = 7'b0000011,
    opc_op_imm    = 7'b0010011,
    opc_auipc     = 7'b0010111,
    opc_op_imm_32 = 7'b0011011,
    opc_store     = 7'b0100011,
    opc_op        = 7'b0110011,
    opc_op_32     = 7'b0111011,
    opc_branch    = 7'b1100011,
    opc_jalr      = 7'b1100111,
    opc_jal       = 7'b1101111
  } opcode_e;

  // what the stage does with an instruction
  typedef enum logic [3:0] {
    cls_op, cls_op_imm, cls_op_32, cls_op_imm_32, cls_auipc,
    cls_branch, cls_jal, cls_jalr, cls_load, cls_store, cls_illegal
  } insn_class_e;

  // alu function
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_e;

  typedef enum logic [2:0] {
    beq, bne, blt, bge, bltu, bgeu
  } br_cond_e;

  // dcache op codes, bit 3 marks a store
  typedef enum logic [3:0] {
    lb  = 4'h0, lh  = 4'h1, lw  = 4'h2, ld = 4'h3,
    lbu = 4'h4, lhu = 4'h5, lwu = 4'h6,
    sb  = 4'h8, sh  = 4'h9, sw  = 4'ha, sd = 4'hb
  } mem_op_e;

  // decoded instruction from the decode stage
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0]     insn;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    reg_idx_t        rd;
  } exe_in_t;

  // register file write
  typedef struct packed {
    reg_idx_t        rd;
    logic [xlen-1:0] data;
    logic            long;
  } wb_t;

  // load/store request to the dcache
  typedef struct packed {
    logic [xlen-1:0] addr;
    logic [xlen-1:0] data;
    mem_op_e         op;
    reg_idx_t        rd;
  } mem_req_t;

endpackage

// ==== hdl/exe_stage.sv ====
`timescale 1ns/1ns

module exe_stage #(
  parameter logic [exe_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         insn_valid,
  input  exe_pkg::exe_in_t             insn_in,
  output logic                         wb_valid,
  output exe_pkg::wb_t                 wb,
  output logic                         redirect_valid,
  output logic [exe_pkg::xlen-1:0]     redirect_target,
  output logic                         mem_valid,
  output exe_pkg::mem_req_t            mem_req
);

  exe_pkg::insn_class_e     insn_class;
  exe_pkg::alu_op_e         alu_op;
  exe_pkg::br_cond_e        br_cond;
  exe_pkg::mem_op_e         mem_op;
  logic [exe_pkg::xlen-1:0] result;
  logic                     is_long;
  logic [exe_pkg::xlen-1:0] mem_addr;
  logic                     accept;
  logic                     taken;
  logic [exe_pkg::xlen-1:0] target;

  // next cycle output values
  logic                     is_wb;
  logic                     is_load;
  logic                     is_store;
  logic                     wb_valid_d;
  logic                     mem_valid_d;
  exe_pkg::wb_t             wb_d;
  exe_pkg::mem_req_t        mem_req_d;

  exe_decode exe_decode_i (
    .insn       (insn_in.insn),
    .insn_class (insn_class),
    .alu_op     (alu_op),
    .br_cond    (br_cond),
    .mem_op     (mem_op)
  );

  exe_alu exe_alu_i (
    .insn_in    (insn_in),
    .insn_class (insn_class),
    .alu_op     (alu_op),
    .result     (result),
    .is_long    (is_long),
    .mem_addr   (mem_addr)
  );

  exe_branch #(
    .reset_pc (reset_pc)
  ) exe_branch_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .insn_valid (insn_valid),
    .insn_in    (insn_in),
    .insn_class (insn_class),
    .br_cond    (br_cond),
    .accept     (accept),
    .taken      (taken),
    .target     (target)
  );

  // classes that write rd
  assign is_wb = insn_class inside {exe_pkg::cls_op, exe_pkg::cls_op_imm,
                                    exe_pkg::cls_op_32, exe_pkg::cls_op_imm_32,
                                    exe_pkg::cls_auipc, exe_pkg::cls_jal,
                                    exe_pkg::cls_jalr};
  assign is_load  = insn_class == exe_pkg::cls_load;
  assign is_store = insn_class == exe_pkg::cls_store;

  assign wb_valid_d  = accept && is_wb;
  assign mem_valid_d = accept && (is_load || is_store);

  assign wb_d.rd   = insn_in.rd;
  assign wb_d.data = result;
  assign wb_d.long = is_long;

  // store carries data, load carries rd
  assign mem_req_d.addr = mem_addr;
  assign mem_req_d.data = is_store ? insn_in.src2 : '0;
  assign mem_req_d.op   = mem_op;
  assign mem_req_d.rd   = is_load ? insn_in.rd : '0;

  // strobes
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_valid       <= 1'b0;
      redirect_valid <= 1'b0;
      mem_valid      <= 1'b0;
    end else begin
      wb_valid       <= wb_valid_d;
      redirect_valid <= taken;
      mem_valid      <= mem_valid_d;
    end
  end

  // payload, loaded only with its strobe
  always_ff @(posedge clk) begin
    if (wb_valid_d) wb <= wb_d;
    if (taken) redirect_target <= target;
    if (mem_valid_d) mem_req <= mem_req_d;
  end

  // an unknown insn word would decode as illegal and vanish silently
  insn_known_a: assert property (
    @(posedge clk) disable iff (!arst_n)
    insn_valid |-> !$isunknown(insn_in.insn)
  );

endmodule

// ==== verif/exe_stim.txt ====
# columns, all hex: valid pc insn imm src1 src2 rd  wb_valid wb_rd wb_data wb_long
#   redirect_valid target  mem_valid addr data op rd  (outputs expected one cycle later)
1 0 002081b3 0 1000 234 3 1 3 1234 1 0 0 0 0 0 0 0
1 4 40208233 0 5 7 4 1 4 fffffffffffffffe 1 0 0 0 0 0 0 0
1 8 0020a2b3 0 ffffffffffffffff 1 5 1 5 1 1 0 0 0 0 0 0 0
1 c 0020b333 0 ffffffffffffffff 1 6 1 6 0 1 0 0 0 0 0 0 0
1 10 002093b3 0 1 43 7 1 7 8 1 0 0 0 0 0 0 0
1 14 0020d433 0 8000000000000000 4 8 1 8 0800000000000000 1 0 0 0 0 0 0 0
1 18 4020d4b3 0 8000000000000000 4 9 1 9 f800000000000000 1 0 0 0 0 0 0 0
1 1c 0020c533 0 ff00 f0f a 1 a f00f 1 0 0 0 0 0 0 0
1 20 0020e5b3 0 f0 f b 1 b ff 1 0 0 0 0 0 0 0
1 24 0020f633 0 ff0 f0f c 1 c f00 1 0 0 0 0 0 0 0
1 28 fff08693 ffffffffffffffff 10 0 d 1 d f 1 0 0 0 0 0 0 0
1 2c 0050a713 5 fffffffffffffffd 0 e 1 e 1 1 0 0 0 0 0 0 0
1 30 fff0b793 ffffffffffffffff 5 0 f 1 f 1 1 0 0 0 0 0 0 0
1 34 4240d813 424 8000000000000000 0 10 1 10 fffffffff8000000 1 0 0 0 0 0 0 0
1 38 02009893 20 3 0 11 1 11 300000000 1 0 0 0 0 0 0 0
1 3c 0020893b 0 7fffffff 1 12 1 12 ffffffff80000000 0 0 0 0 0 0 0 0
1 40 402089bb 0 123400000000 1 13 1 13 ffffffffffffffff 0 0 0 0 0 0 0 0
1 44 00209a3b 0 1 3f 14 1 14 ffffffff80000000 0 0 0 0 0 0 0 0
1 48 4020dabb 0 80000000 4 15 1 15 fffffffff8000000 0 0 0 0 0 0 0 0
1 4c ffe08b1b fffffffffffffffe 100000001 0 16 1 16 ffffffffffffffff 0 0 0 0 0 0 0 0
1 50 4080db9b 408 ff000000 0 17 1 17 ffffffffffff0000 0 0 0 0 0 0 0 0
1 54 12345c17 12345000 0 0 18 1 18 12345054 1 0 0 0 0 0 0 0
1 58 100000ef 100 0 0 1 1 1 5c 1 1 158 0 0 0 0 0
1 5c 002081b3 0 1 1 3 0 0 0 0 0 0 0 0 0 0 0
1 60 fff08693 ffffffffffffffff 1 0 d 0 0 0 0 0 0 0 0 0 0 0
1 158 011082e7 11 1000 0 5 1 5 15c 1 1 1010 0 0 0 0 0
0 1010 00208463 8 5 5 0 0 0 0 0 0 0 0 0 0 0 0
1 1010 00208463 8 5 5 0 0 0 0 0 1 1018 0 0 0 0 0
1 1014 002081b3 0 1 1 3 0 0 0 0 0 0 0 0 0 0 0
1 1018 00208463 8 5 6 0 0 0 0 0 0 0 0 0 0 0 0
1 101c 00209463 8 5 6 0 0 0 0 0 1 1024 0 0 0 0 0
1 1024 00209463 8 7 7 0 0 0 0 0 0 0 0 0 0 0 0
1 1028 0020c463 8 ffffffffffffffff 1 0 0 0 0 0 1 1030 0 0 0 0 0
1 1030 0020c463 8 1 ffffffffffffffff 0 0 0 0 0 0 0 0 0 0 0 0
1 1034 0020d463 8 1 ffffffffffffffff 0 0 0 0 0 1 103c 0 0 0 0 0
1 103c 0020d463 8 ffffffffffffffff 1 0 0 0 0 0 0 0 0 0 0 0 0
1 1040 0020e463 8 1 ffffffffffffffff 0 0 0 0 0 1 1048 0 0 0 0 0
1 1048 0020e463 8 ffffffffffffffff 1 0 0 0 0 0 0 0 0 0 0 0 0
1 104c 0020f463 8 ffffffffffffffff 1 0 0 0 0 0 1 1054 0 0 0 0 0
1 1054 0020f463 8 1 2 0 0 0 0 0 0 0 0 0 0 0 0
1 1058 022081b3 0 1 2 3 0 0 0 0 0 0 0 0 0 0 0
1 105c 01008303 10 2000 ffff 6 0 0 0 0 0 0 1 2010 0 0 6
1 1060 ff009303 fffffffffffffff0 2000 ffff 6 0 0 0 0 0 0 1 1ff0 0 1 6
1 1064 0100a303 10 3000 ffff 6 0 0 0 0 0 0 1 3010 0 2 6
1 1068 0100b303 10 4000 ffff 6 0 0 0 0 0 0 1 4010 0 3 6
1 106c 0100c303 10 5000 ffff 6 0 0 0 0 0 0 1 5010 0 4 6
1 1070 0100d303 10 6000 ffff 6 0 0 0 0 0 0 1 6010 0 5 6
1 1074 0100e303 10 7000 ffff 6 0 0 0 0 0 0 1 7010 0 6 6
1 1078 00208423 8 8000 aa 9 0 0 0 0 0 0 1 8008 aa 8 0
1 107c 00209423 8 8000 bbbb 9 0 0 0 0 0 0 1 8008 bbbb 9 0
1 1080 0020a423 8 8000 cccccccc 9 0 0 0 0 0 0 1 8008 cccccccc a 0
1 1084 0020b423 8 8000 1122334455667788 9 0 0 0 0 0 0 1 8008 1122334455667788 b 0
1 1088 00108693 1 41 0 d 1 d 42 1 0 0 0 0 0 0 0

// ==== verif/exe_tb.sv ====
`timescale 1ns/1ns

module exe_tb;

  localparam int clk_period   = 4;
  localparam int reset_cycles = 16;
  // slack on top of the expected run length
  localparam int margin_ns    = 200;
  localparam int field_count  = 18;
  localparam string stim_path = "verif/exe_stim.txt";

  // one stimulus line, the inputs plus what should come out a cycle later
  typedef struct packed {
    logic                     valid;
    exe_pkg::exe_in_t         in;
    logic                     wb_valid;
    exe_pkg::wb_t             wb;
    logic                     redirect_valid;
    logic [exe_pkg::xlen-1:0] target;
    logic                     mem_valid;
    exe_pkg::mem_req_t        mem;
  } vector_t;

  logic                     clk;
  logic                     arst_n;
  logic                     insn_valid;
  exe_pkg::exe_in_t         insn_in;
  logic                     wb_valid;
  exe_pkg::wb_t             wb;
  logic                     redirect_valid;
  logic [exe_pkg::xlen-1:0] redirect_target;
  logic                     mem_valid;
  exe_pkg::mem_req_t        mem_req;

  vector_t vectors[$];
  bit      loaded;

  tb_clock #(
    .period (clk_period)
  ) tb_clock_i (
    .clk (clk)
  );

  exe_stage exe_stage_i (
    .clk             (clk),
    .arst_n          (arst_n),
    .insn_valid      (insn_valid),
    .insn_in         (insn_in),
    .wb_valid        (wb_valid),
    .wb              (wb),
    .redirect_valid  (redirect_valid),
    .redirect_target (redirect_target),
    .mem_valid       (mem_valid),
    .mem_req         (mem_req)
  );

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_value(input string name, input int idx,
                              input logic [63:0] exp, input logic [63:0] got);
    stop_run($sformatf("Fail %s at vector %0d: expected %h, got %h", name, idx, exp, got));
  endtask

  // payload only matters while its strobe is up
  task automatic check_wb(input int idx, input logic exp_valid, input exe_pkg::wb_t exp,
                          input logic got_valid, input exe_pkg::wb_t got);
    if (got_valid !== exp_valid) begin
      report_value("wb_valid", idx, 64'(exp_valid), 64'(got_valid));
    end else if (exp_valid && got.rd !== exp.rd) begin
      report_value("wb.rd", idx, 64'(exp.rd), 64'(got.rd));
    end else if (exp_valid && got.data !== exp.data) begin
      report_value("wb.data", idx, exp.data, got.data);
    end else if (exp_valid && got.long !== exp.long) begin
      report_value("wb.long", idx, 64'(exp.long), 64'(got.long));
    end
  endtask

  task automatic check_redirect(input int idx, input logic exp_valid,
                                input logic [exe_pkg::xlen-1:0] exp,
                                input logic got_valid, input logic [exe_pkg::xlen-1:0] got);
    if (got_valid !== exp_valid) begin
      report_value("redirect_valid", idx, 64'(exp_valid), 64'(got_valid));
    end else if (exp_valid && got !== exp) begin
      report_value("redirect_target", idx, exp, got);
    end
  endtask

  task automatic check_mem(input int idx, input logic exp_valid, input exe_pkg::mem_req_t exp,
                           input logic got_valid, input exe_pkg::mem_req_t got);
    if (got_valid !== exp_valid) begin
      report_value("mem_valid", idx, 64'(exp_valid), 64'(got_valid));
    end else if (exp_valid && got.addr !== exp.addr) begin
      report_value("mem_req.addr", idx, exp.addr, got.addr);
    end else if (exp_valid && got.data !== exp.data) begin
      report_value("mem_req.data", idx, exp.data, got.data);
    end else if (exp_valid && got.op !== exp.op) begin
      report_value("mem_req.op", idx, 64'(exp.op), 64'(got.op));
    end else if (exp_valid && got.rd !== exp.rd) begin
      report_value("mem_req.rd", idx, 64'(exp.rd), 64'(got.rd));
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          count;
    int          line_no;
    string       line;
    vector_t     v;
    logic        valid_f, wbv_f, wbl_f, rv_f, mv_f;
    logic [31:0] insn_f;
    logic [4:0]  rd_f, wbrd_f, mrd_f;
    logic [3:0]  op_f;
    logic [63:0] pc_f, imm_f, src1_f, src2_f, wbd_f, tgt_f, addr_f, mdata_f;
    line_no = 0;
    fd = $fopen(stim_path, "r");
    if (fd == 0) begin
      stop_run({"cannot open the stimulus file ", stim_path});
    end else begin
      while ($fgets(line, fd) != 0) begin
        line_no++;
        // skip comments and empty lines
        if (line.len() > 1 && line.getc(0) != "#") begin
          count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          valid_f, pc_f, insn_f, imm_f, src1_f, src2_f, rd_f,
                          wbv_f, wbrd_f, wbd_f, wbl_f, rv_f, tgt_f,
                          mv_f, addr_f, mdata_f, op_f, mrd_f);
          if (count != field_count) begin
            stop_run($sformatf("stimulus line %0d does not hold %0d fields", line_no,
                               field_count));
          end
          v.valid          = valid_f;
          v.in.pc          = pc_f;
          v.in.insn        = insn_f;
          v.in.imm         = imm_f;
          v.in.src1        = src1_f;
          v.in.src2        = src2_f;
          v.in.rd          = rd_f;
          v.wb_valid       = wbv_f;
          v.wb.rd          = wbrd_f;
          v.wb.data        = wbd_f;
          v.wb.long        = wbl_f;
          v.redirect_valid = rv_f;
          v.target         = tgt_f;
          v.mem_valid      = mv_f;
          v.mem.addr       = addr_f;
          v.mem.data       = mdata_f;
          v.mem.op         = exe_pkg::mem_op_e'(op_f);
          v.mem.rd         = mrd_f;
          vectors.push_back(v);
        end
      end
      $fclose(fd);
    end
    if (vectors.size() == 0) begin
      stop_run("the stimulus file holds no vectors");
    end
    loaded = 1'b1;
  endtask

  task automatic drive_vector(input vector_t v);
    insn_valid <= v.valid;
    insn_in    <= v.in;
  endtask

  task automatic check_vector(input int idx);
    vector_t v;
    v = vectors[idx];
    check_wb(idx, v.wb_valid, v.wb, wb_valid, wb);
    check_redirect(idx, v.redirect_valid, v.target, redirect_valid, redirect_target);
    check_mem(idx, v.mem_valid, v.mem, mem_valid, mem_req);
  endtask

  initial begin
    int idx;
    arst_n     = 1'b0;
    insn_valid = 1'b0;
    insn_in    = '0;
    load_vectors();
    repeat (reset_cycles) @(posedge clk);
    arst_n <= 1'b1;
    // drive on the rising edge, look at results on the falling one
    for (idx = 0; idx <= vectors.size(); idx++) begin
      @(posedge clk);
      if (idx < vectors.size()) begin
        drive_vector(vectors[idx]);
      end else begin
        insn_valid <= 1'b0;
      end
      @(negedge clk);
      if (idx == 0) begin
        // nothing accepted yet, all strobes still low after reset
        check_wb(-1, 1'b0, '0, wb_valid, wb);
        check_redirect(-1, 1'b0, '0, redirect_valid, redirect_target);
        check_mem(-1, 1'b0, '0, mem_valid, mem_req);
      end else begin
        check_vector(idx - 1);
      end
    end
    $display("STATUS: PASS");
    $finish;
  end

  // watchdog, sized from the vector count once the file is in
  initial begin
    int limit_ns;
    wait (loaded);
    limit_ns = (reset_cycles + vectors.size() + 2) * clk_period + margin_ns;
    #(limit_ns);
    stop_run("the run timed out before all vectors were checked");
  end

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
  parameter int period = 4
) (
  output logic clk
);

  // free running, starts low
  initial begin
    clk = 1'b0;
    forever begin
      #(period / 2) clk = ~clk;
    end
  end

endmodule
